//--- verilog/cpuPkg.sv
package cpuPkg;

  // ==============================
  // Widths and types
  // ==============================
  localparam int dataWidth  = 32;
  localparam int regNoWidth = 4;
  localparam int immWidth   = 16;
  localparam int regCount   = 1 << regNoWidth;

  typedef logic [dataWidth-1:0]  word_t;
  typedef logic [regNoWidth-1:0] regNo_t;

  // PC and memory geometry
  localparam word_t startPc        = 32'h100;
  localparam word_t instSize       = 32'd4;
  localparam int    byteOffsetBits = $clog2(instSize);
  localparam int    imemWords      = 1024;
  localparam int    dmemWords      = 1024;
  localparam int    imemIdxWidth   = $clog2(imemWords);
  localparam int    dmemIdxWidth   = $clog2(dmemWords);

  // ==============================
  // Memory-mapped I/O
  // ==============================
  localparam word_t addrLedr = 32'hFFFFF020;
  localparam word_t addrHex  = 32'hFFFFF000;
  localparam word_t ioMask   = 32'hFFFFF000;

  localparam int ledrWidth = 10;
  localparam int hexWidth  = 24;
  localparam logic [hexWidth-1:0] hexResetValue = 24'hFEDEAD;

  // ==============================
  // Opcodes and control
  // ==============================
  typedef enum logic [5:0] {
    ALUR = 6'h00, BEQ  = 6'h08, BLT  = 6'h09, BLE  = 6'h0A,
    BNE  = 6'h0B, JAL  = 6'h0C, LW   = 6'h12, SW   = 6'h1A,
    ADDI = 6'h20, ANDI = 6'h24, ORI  = 6'h25, XORI = 6'h26
  } op1_t;

  typedef enum logic [7:0] {
    EQ   = 8'h08, LT   = 8'h09, LE   = 8'h0A, NE   = 8'h0B,
    ADD  = 8'h20, AND  = 8'h24, OR   = 8'h25, XOR  = 8'h26,
    SUB  = 8'h28, NAND = 8'h2C, NOR  = 8'h2D, NXOR = 8'h2E,
    RSHF = 8'h30, LSHF = 8'h31
  } op2_t;

  typedef struct packed {
    logic isBranch;
    logic isJump;
    logic readMem;
    logic writeMem;
    logic writeReg;
  } ctrl_t;

endpackage

//--- verilog/pipeIf.sv
`timescale 1ns/100ps

// Decode latch contents, seen by execute
interface decodeBus import cpuPkg::*; ();
  word_t  pc;
  op1_t   op1;
  op2_t   op2;
  word_t  imm;
  word_t  val1;
  word_t  val2;
  regNo_t wregNo;
  ctrl_t  ctrl;

  modport source (output pc, op1, op2, imm, val1, val2, wregNo, ctrl);
  modport sink   (input  pc, op1, op2, imm, val1, val2, wregNo, ctrl);
endinterface

// Execute latch contents, seen by the result stage
interface execBus import cpuPkg::*; ();
  word_t  aluOut;
  word_t  storeVal;
  regNo_t wregNo;
  ctrl_t  ctrl;

  modport source (output aluOut, storeVal, wregNo, ctrl);
  modport sink   (input  aluOut, storeVal, wregNo, ctrl);
  // Decode only looks at the destination for hazards
  modport snoop  (input  wregNo, ctrl);
endinterface

//--- verilog/instrFetch.sv
`timescale 1ns/100ps

module instrFetch import cpuPkg::*; (
  input  logic                    clk,
  input  logic                    RESET,
  input  logic                    progWrite,
  input  logic [imemIdxWidth-1:0] progAddr,
  input  word_t                   progData,
  input  logic                    stall,
  input  logic                    redirect,
  input  word_t                   redirectPc,
  output word_t                   instr,
  output word_t                   instrPc
);

  word_t imem [imemWords];
  word_t pc;
  word_t fetched;

  // Program load port
  always_ff @(posedge clk) begin
    if (progWrite) begin
      imem[progAddr] <= progData;
    end
  end

  assign fetched = imem[pc[byteOffsetBits +: imemIdxWidth]];

  // Redirect wins over stall
  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      pc <= startPc;
    end else if (redirect) begin
      pc <= redirectPc;
    end else if (!stall) begin
      pc <= pc + instSize;
    end
  end

  // ==============================
  // Fetch latch
  // ==============================
  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      instr <= '0;
    end else if (redirect) begin
      instr <= '0;
    end else if (!stall) begin
      instr <= fetched;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      instrPc <= pc;
    end
  end

endmodule

//--- verilog/instrDecode.sv
`timescale 1ns/100ps

module instrDecode import cpuPkg::*; (
  input  logic     clk,
  input  logic     RESET,
  input  word_t    instr,
  input  word_t    instrPc,
  input  logic     redirect,
  input  word_t    exFwd,
  input  word_t    memFwd,
  input  logic     wbEn,
  input  regNo_t   wbNo,
  input  word_t    wbVal,
  output logic     stall,
  decodeBus.source dec,
  execBus.snoop    ex
);

  op1_t   op1;
  op2_t   op2;
  word_t  immExt;
  regNo_t rd;
  regNo_t rs;
  regNo_t rt;
  regNo_t wregNo;
  ctrl_t  ctrl;
  logic   readsRt;
  word_t  regs [regCount];

  // ==============================
  // Field decode
  // ==============================
  assign op1    = op1_t'(instr[31:26]);
  assign op2    = op2_t'(instr[25:18]);
  assign immExt = {{(dataWidth-immWidth){instr[23]}}, instr[23:8]};
  assign rd     = instr[11:8];
  assign rs     = instr[7:4];
  assign rt     = instr[3:0];

  // ALUR writes rd, everything else writes rt
  assign wregNo = (op1 == ALUR) ? rd : rt;

  // Immediate ops share the 100 prefix and never read rt
  assign readsRt = !(op1 == JAL || op1 == LW || instr[31:29] == 3'b100);

  always_comb begin
    ctrl = '0;
    case (op1)
      ALUR, ADDI, ANDI, ORI, XORI: ctrl.writeReg = 1'b1;
      BEQ, BLT, BLE, BNE:          ctrl.isBranch = 1'b1;
      JAL: begin
        ctrl.isJump   = 1'b1;
        ctrl.writeReg = 1'b1;
      end
      LW: begin
        ctrl.readMem  = 1'b1;
        ctrl.writeReg = 1'b1;
      end
      SW:      ctrl.writeMem = 1'b1;
      default: ctrl = '0;
    endcase
    // All-zero word is the fetch bubble
    if (instr == '0) begin
      ctrl = '0;
    end
  end

  // Load in the decode latch feeding the instruction being decoded
  assign stall = dec.ctrl.readMem &&
                 (rs == dec.wregNo || (readsRt && rt == dec.wregNo));

  // ==============================
  // Register file and bypass
  // ==============================
  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (wbEn) begin
      regs[wbNo] <= wbVal;
    end
  end

  // Youngest producer first, write port last
  function automatic word_t pickOperand(input regNo_t r);
    word_t v;
    if (dec.ctrl.writeReg && dec.wregNo == r) begin
      v = exFwd;
    end else if (ex.ctrl.writeReg && ex.wregNo == r) begin
      v = memFwd;
    end else if (wbEn && wbNo == r) begin
      v = wbVal;
    end else begin
      v = regs[r];
    end
    return v;
  endfunction

  // Decode latch
  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      dec.ctrl <= '0;
    end else if (redirect || stall) begin
      dec.ctrl <= '0;
    end else begin
      dec.ctrl <= ctrl;
    end
  end

  always_ff @(posedge clk) begin
    dec.pc     <= instrPc;
    dec.op1    <= op1;
    dec.op2    <= op2;
    dec.imm    <= immExt;
    dec.val1   <= pickOperand(rs);
    dec.val2   <= pickOperand(rt);
    dec.wregNo <= wregNo;
  end

endmodule

//--- verilog/executeStage.sv
`timescale 1ns/100ps

module executeStage import cpuPkg::*; (
  input  logic   clk,
  input  logic   RESET,
  decodeBus.sink dec,
  execBus.source ex,
  output word_t  exFwd,
  output logic   redirect,
  output word_t  redirectPc
);

  logic signed [dataWidth-1:0] opA;
  logic signed [dataWidth-1:0] opB;
  word_t aluOut;
  logic  branchCond;

  assign opA = dec.val1;
  assign opB = dec.val2;

  function automatic word_t flag(input logic b);
    return {{(dataWidth-1){1'b0}}, b};
  endfunction

  // ==============================
  // ALU
  // ==============================
  always_comb begin
    aluOut = '0;
    case (dec.op1)
      ALUR: begin
        case (dec.op2)
          EQ:      aluOut = flag(opA == opB);
          LT:      aluOut = flag(opA < opB);
          LE:      aluOut = flag(opA <= opB);
          NE:      aluOut = flag(opA != opB);
          ADD:     aluOut = opA + opB;
          SUB:     aluOut = opA - opB;
          AND:     aluOut = opA & opB;
          OR:      aluOut = opA | opB;
          XOR:     aluOut = opA ^ opB;
          NAND:    aluOut = ~(opA & opB);
          NOR:     aluOut = ~(opA | opB);
          NXOR:    aluOut = opA ~^ opB;
          RSHF:    aluOut = dec.val1 >> dec.val2;
          LSHF:    aluOut = dec.val1 << dec.val2;
          default: aluOut = '0;
        endcase
      end
      ADDI, LW, SW: aluOut = dec.val1 + dec.imm;
      ANDI:         aluOut = dec.val1 & dec.imm;
      ORI:          aluOut = dec.val1 | dec.imm;
      XORI:         aluOut = dec.val1 ^ dec.imm;
      // Link value is the return address
      JAL:          aluOut = dec.pc + instSize;
      default:      aluOut = '0;
    endcase
  end

  assign exFwd = aluOut;

  // Signed branch compare
  always_comb begin
    case (dec.op1)
      BEQ:     branchCond = (opA == opB);
      BLT:     branchCond = (opA < opB);
      BLE:     branchCond = (opA <= opB);
      BNE:     branchCond = (opA != opB);
      default: branchCond = 1'b0;
    endcase
  end

  assign redirect   = dec.ctrl.isJump || (dec.ctrl.isBranch && branchCond);
  assign redirectPc = dec.ctrl.isJump ? dec.val1 + (dec.imm << 2)
                                      : dec.pc + (dec.imm << 2);

  // Execute latch
  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      ex.ctrl <= '0;
    end else begin
      ex.ctrl <= dec.ctrl;
    end
  end

  always_ff @(posedge clk) begin
    ex.aluOut   <= aluOut;
    ex.storeVal <= dec.val2;
    ex.wregNo   <= dec.wregNo;
  end

endmodule

//--- verilog/resultStage.sv
`timescale 1ns/100ps

module resultStage import cpuPkg::*; (
  input  logic                 clk,
  input  logic                 RESET,
  execBus.sink                 ex,
  output word_t                memFwd,
  output logic                 wbEn,
  output regNo_t               wbNo,
  output word_t                wbVal,
  output logic [ledrWidth-1:0] ledr,
  output logic [hexWidth-1:0]  hex
);

  word_t dmem [dmemWords];
  logic [dmemIdxWidth-1:0] memIdx;
  logic  isIo;
  logic  selLedr;
  logic  selHex;
  word_t loadVal;

  assign memIdx  = ex.aluOut[byteOffsetBits +: dmemIdxWidth];
  assign isIo    = (ex.aluOut & ioMask) == ioMask;
  assign selLedr = (ex.aluOut == addrLedr);
  assign selHex  = (ex.aluOut == addrHex);

  // ==============================
  // Stores
  // ==============================
  always_ff @(posedge clk) begin
    if (ex.ctrl.writeMem && !isIo) begin
      dmem[memIdx] <= ex.storeVal;
    end
  end

  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      ledr <= '0;
      hex  <= hexResetValue;
    end else if (ex.ctrl.writeMem && isIo) begin
      if (selLedr) begin
        ledr <= ex.storeVal[ledrWidth-1:0];
      end
      if (selHex) begin
        hex <= ex.storeVal[hexWidth-1:0];
      end
    end
  end

  // Unmapped I/O reads as zero
  always_comb begin
    if (!isIo) begin
      loadVal = dmem[memIdx];
    end else if (selLedr) begin
      loadVal = word_t'(ledr);
    end else if (selHex) begin
      loadVal = word_t'(hex);
    end else begin
      loadVal = '0;
    end
  end

  assign memFwd = ex.ctrl.readMem ? loadVal : ex.aluOut;

  // Memory latch drives the register write port
  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      wbEn <= 1'b0;
    end else begin
      wbEn <= ex.ctrl.writeReg;
    end
  end

  always_ff @(posedge clk) begin
    wbNo  <= ex.wregNo;
    wbVal <= memFwd;
  end

endmodule

//--- verilog/cpuTop.sv
`timescale 1ns/100ps

module cpuTop import cpuPkg::*; (
  input  logic                    clk,
  input  logic                    RESET,
  input  logic                    progWrite,
  input  logic [imemIdxWidth-1:0] progAddr,
  input  word_t                   progData,
  output logic [ledrWidth-1:0]    ledr,
  output logic [hexWidth-1:0]     hex
);

  word_t  instr;
  word_t  instrPc;
  logic   stall;
  logic   redirect;
  word_t  redirectPc;
  word_t  exFwd;
  word_t  memFwd;
  logic   wbEn;
  regNo_t wbNo;
  word_t  wbVal;

  decodeBus decBus ();
  execBus   exBus ();

  instrFetch i_instrFetch (
    .clk, .RESET, .progWrite, .progAddr, .progData,
    .stall, .redirect, .redirectPc, .instr, .instrPc
  );

  instrDecode i_instrDecode (
    .clk, .RESET, .instr, .instrPc, .redirect, .exFwd, .memFwd,
    .wbEn, .wbNo, .wbVal, .stall, .dec(decBus), .ex(exBus)
  );

  executeStage i_executeStage (
    .clk, .RESET, .dec(decBus), .ex(exBus), .exFwd, .redirect, .redirectPc
  );

  resultStage i_resultStage (
    .clk, .RESET, .ex(exBus), .memFwd, .wbEn, .wbNo, .wbVal, .ledr, .hex
  );

endmodule

//--- bench/pipeline_props.sv
`timescale 1ns/100ps

module pipelineProps import cpuPkg::*; (
  input logic  clk,
  input logic  RESET,
  input logic  stall,
  input logic  redirect,
  input ctrl_t decCtrl
);

  // Load-use stall lasts one cycle
  stallOnce: assert property (@(posedge clk) disable iff (RESET) stall |=> !stall)
    else $error("stall held for two cycles");

  // Decode latch takes a bubble after stall or redirect
  bubbleAfter: assert property (@(posedge clk) disable iff (RESET)
    (stall || redirect) |=> (decCtrl == '0))
    else $error("decode latch not a bubble after stall or redirect");

endmodule

bind instrDecode pipelineProps i_pipelineProps (
  .clk(clk), .RESET(RESET), .stall(stall), .redirect(redirect), .decCtrl(dec.ctrl)
);

//--- bench/isaModel.svh
// ==============================
// Instruction encoders
// ==============================
function automatic word_t encAlu(input op2_t f, input regNo_t rd, input regNo_t rs,
                                 input regNo_t rt);
  return {ALUR, f, 6'b0, rd, rs, rt};
endfunction

// Immediate, memory, branch and jump format
function automatic word_t encImm(input op1_t op, input regNo_t rt, input regNo_t rs,
                                 input logic [immWidth-1:0] imm);
  return {op, 2'b0, imm, rs, rt};
endfunction

function automatic word_t aluFn(input op2_t f, input word_t a, input word_t b);
  word_t res;
  case (f)
    EQ:      res = word_t'($signed(a) == $signed(b));
    LT:      res = word_t'($signed(a) < $signed(b));
    LE:      res = word_t'($signed(a) <= $signed(b));
    NE:      res = word_t'($signed(a) != $signed(b));
    ADD:     res = a + b;
    SUB:     res = a - b;
    AND:     res = a & b;
    OR:      res = a | b;
    XOR:     res = a ^ b;
    NAND:    res = ~(a & b);
    NOR:     res = ~(a | b);
    NXOR:    res = ~(a ^ b);
    RSHF:    res = a >> b;
    LSHF:    res = a << b;
    default: res = '0;
  endcase
  return res;
endfunction

// Runs until the self-loop, records every change of LEDR in expLedr
function automatic void runProgram(input word_t prog[$],
                                   output logic [ledrWidth-1:0] ledrOut,
                                   output logic [hexWidth-1:0] hexOut);
  word_t  r [regCount];
  word_t  dm [word_t];
  word_t  pc;
  word_t  ins;
  word_t  a;
  word_t  b;
  word_t  imm;
  word_t  addr;
  word_t  nextPc;
  word_t  idx;
  op1_t   op;
  regNo_t rs;
  regNo_t rt;
  logic   taken;
  for (int i = 0; i < regCount; i++) begin
    r[i] = '0;
  end
  ledrOut = '0;
  hexOut  = hexResetValue;
  pc      = startPc;
  for (int steps = 0; steps < 4000; steps++) begin
    idx = (pc - startPc) >> 2;
    if (pc < startPc || idx >= prog.size()) begin
      break;
    end
    ins    = prog[idx];
    op     = op1_t'(ins[31:26]);
    rs     = ins[7:4];
    rt     = ins[3:0];
    imm    = {{(dataWidth-immWidth){ins[23]}}, ins[23:8]};
    a      = r[rs];
    b      = r[rt];
    addr   = a + imm;
    nextPc = pc + 4;
    taken  = 1'b0;
    case (op)
      ALUR: r[ins[11:8]] = aluFn(op2_t'(ins[25:18]), a, b);
      ADDI: r[rt] = a + imm;
      ANDI: r[rt] = a & imm;
      ORI:  r[rt] = a | imm;
      XORI: r[rt] = a ^ imm;
      LW: begin
        if ((addr & ioMask) != ioMask) begin
          r[rt] = dm.exists(addr >> 2) ? dm[addr >> 2] : '0;
        end else if (addr == addrLedr) begin
          r[rt] = word_t'(ledrOut);
        end else if (addr == addrHex) begin
          r[rt] = word_t'(hexOut);
        end else begin
          r[rt] = '0;
        end
      end
      SW: begin
        if ((addr & ioMask) != ioMask) begin
          dm[addr >> 2] = b;
        end else if (addr == addrLedr) begin
          if (b[ledrWidth-1:0] != ledrOut) begin
            expLedr.push_back(b[ledrWidth-1:0]);
          end
          ledrOut = b[ledrWidth-1:0];
        end else if (addr == addrHex) begin
          hexOut = b[hexWidth-1:0];
        end
      end
      BEQ: taken = ($signed(a) == $signed(b));
      BLT: taken = ($signed(a) < $signed(b));
      BLE: taken = ($signed(a) <= $signed(b));
      BNE: taken = ($signed(a) != $signed(b));
      JAL: begin
        r[rt]  = pc + 4;
        nextPc = a + (imm << 2);
      end
      default: ;
    endcase
    if (taken) begin
      nextPc = pc + (imm << 2);
    end
    if (nextPc == pc) begin
      break;
    end
    pc = nextPc;
  end
endfunction

//--- bench/cpuTb.sv
`timescale 1ns/100ps

module cpuTb import cpuPkg::*; ();

  localparam int runTimeout = 5000;
  localparam regNo_t ioBase = 4'd15;

  logic clk = 1'b0;
  logic RESET;
  logic progWrite;
  logic [imemIdxWidth-1:0] progAddr;
  word_t progData;
  logic [ledrWidth-1:0] ledr;
  logic [hexWidth-1:0] hex;

  word_t prog [$];
  logic [ledrWidth-1:0] expLedr [$];
  logic [ledrWidth-1:0] seenLedr;
  logic watching = 1'b0;
  int errorCount = 0;

  op2_t aluOps [14] = '{EQ, LT, LE, NE, ADD, SUB, AND, OR, XOR, NAND, NOR, NXOR,
                        RSHF, LSHF};

  `include "isaModel.svh"

  cpuTop i_cpuTop (
    .clk, .RESET, .progWrite, .progAddr, .progData, .ledr, .hex
  );

  always #2 clk = ~clk;

  task automatic checkEq(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      errorCount++;
      $display("Mismatch at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Regression failed");
      $fatal(1, "Stopping on first error");
    end
  endtask

  // ==============================
  // LEDR compare process
  // ==============================
  always @(negedge clk) begin
    if (watching && ledr != seenLedr) begin
      if (expLedr.size() == 0) begin
        checkEq(word_t'(ledr), word_t'(seenLedr), "LEDR written with no write expected");
      end else begin
        checkEq(word_t'(ledr), word_t'(expLedr.pop_front()), "LEDR write sequence");
      end
      seenLedr = ledr;
    end
  end

  // Program building helpers
  task automatic emit(input word_t w);
    prog.push_back(w);
  endtask

  task automatic storeLedr(input regNo_t r);
    emit(encImm(SW, r, ioBase, 16'h0020));
  endtask

  task automatic finishProgram(input logic [immWidth-1:0] marker);
    emit(encImm(ADDI, 4'd13, 4'd0, marker));
    emit(encImm(SW, 4'd13, ioBase, 16'h0000));
    emit(encImm(BEQ, 4'd0, 4'd0, 16'h0000));
  endtask

  task automatic buildAluProgram();
    op2_t   f;
    regNo_t rd;
    for (int r = 1; r <= 6; r++) begin
      emit(encImm(ADDI, regNo_t'(r), 4'd0, 16'($urandom)));
    end
    emit(encImm(ADDI, 4'd7, 4'd0, 16'($urandom_range(0, 31))));
    for (int i = 0; i < 24; i++) begin
      f  = aluOps[$urandom_range(0, 13)];
      rd = regNo_t'($urandom_range(1, 6));
      // Shift amounts come from r7 so results stay nonzero
      emit(encAlu(f, rd, regNo_t'($urandom_range(1, 6)),
                  (f == RSHF || f == LSHF) ? 4'd7 : regNo_t'($urandom_range(1, 6))));
      storeLedr(rd);
    end
  endtask

  task automatic buildImmProgram();
    op1_t ops [4] = '{ADDI, ANDI, ORI, XORI};
    emit(encImm(ADDI, 4'd1, 4'd0, 16'($urandom)));
    for (int i = 0; i < 16; i++) begin
      emit(encImm(ops[i % 4], 4'd1, 4'd1, 16'($urandom) | 16'h8000));
      storeLedr(4'd1);
    end
  endtask

  task automatic buildMemProgram();
    emit(encImm(ADDI, 4'd1, 4'd0, 16'($urandom)));
    emit(encImm(ADDI, 4'd2, 4'd0, 16'($urandom)));
    emit(encImm(ADDI, 4'd4, 4'd0, 16'h0040));
    emit(encImm(SW, 4'd1, 4'd4, 16'h0000));
    emit(encImm(SW, 4'd2, 4'd4, 16'h0004));
    emit(encImm(LW, 4'd5, 4'd4, 16'h0000));
    emit(encAlu(ADD, 4'd6, 4'd5, 4'd2));
    storeLedr(4'd6);
    emit(encImm(LW, 4'd7, 4'd4, 16'h0004));
    storeLedr(4'd7);
    emit(encImm(ADDI, 4'd8, 4'd4, 16'h0008));
    emit(encImm(LW, 4'd9, 4'd8, 16'hFFFC));
    emit(encAlu(SUB, 4'd10, 4'd1, 4'd9));
    storeLedr(4'd10);
    emit(encImm(LW, 4'd11, ioBase, 16'h0020));
    emit(encImm(XORI, 4'd11, 4'd11, 16'hFFF5));
    storeLedr(4'd11);
  endtask

  // Branch with offset 3 over two stores, then a counted landing
  task automatic branchCase(input op1_t op, input regNo_t rs, input regNo_t rt);
    emit(encImm(op, rt, rs, 16'h0003));
    storeLedr(4'd10);
    storeLedr(4'd11);
    emit(encImm(ADDI, 4'd12, 4'd12, 16'h0001));
    storeLedr(4'd12);
  endtask

  task automatic buildBranchProgram();
    emit(encImm(ADDI, 4'd1, 4'd0, 16'h0005));
    emit(encImm(ADDI, 4'd2, 4'd0, 16'hFFFD));
    emit(encImm(ADDI, 4'd3, 4'd0, 16'h0005));
    emit(encImm(ADDI, 4'd10, 4'd0, 16'h03FF));
    emit(encImm(ADDI, 4'd11, 4'd0, 16'h0155));
    emit(encImm(ADDI, 4'd12, 4'd0, 16'h0100));
    branchCase(BEQ, 4'd1, 4'd3);
    branchCase(BEQ, 4'd1, 4'd2);
    branchCase(BLT, 4'd2, 4'd1);
    branchCase(BLT, 4'd1, 4'd2);
    branchCase(BLE, 4'd1, 4'd3);
    branchCase(BLE, 4'd1, 4'd2);
    branchCase(BNE, 4'd1, 4'd2);
    branchCase(BNE, 4'd1, 4'd3);
    // Absolute jump past two stores, link lands in r9
    emit(encImm(JAL, 4'd9, 4'd0, 16'((startPc >> 2) + prog.size() + 3)));
    storeLedr(4'd10);
    storeLedr(4'd11);
    storeLedr(4'd9);
  endtask

  task automatic runTest(input int num, input logic [immWidth-1:0] marker);
    logic [ledrWidth-1:0] modelLedr;
    logic [hexWidth-1:0]  modelHex;
    int cycles;
    expLedr.delete();
    runProgram(prog, modelLedr, modelHex);
    @(negedge clk);
    RESET = 1'b1;
    for (int i = 0; i < prog.size(); i++) begin
      progWrite = 1'b1;
      progAddr  = imemIdxWidth'((startPc >> 2) + i);
      progData  = prog[i];
      @(negedge clk);
    end
    progWrite = 1'b0;
    repeat (5) @(negedge clk);
    checkEq(word_t'(ledr), '0, "LEDR after reset");
    checkEq(word_t'(hex), word_t'(hexResetValue), "HEX after reset");
    seenLedr = ledr;
    watching = 1'b1;
    RESET    = 1'b0;
    for (cycles = 0; cycles < runTimeout && hex != hexWidth'(marker); cycles++) begin
      @(negedge clk);
    end
    if (hex != hexWidth'(marker)) begin
      $display("Program %0d did not finish, HEX never showed its end marker", num);
      $display("Regression failed");
      $fatal(1, "Timeout");
    end
    @(negedge clk);
    watching = 1'b0;
    checkEq(expLedr.size(), 0, "LEDR writes still missing");
    checkEq(word_t'(ledr), word_t'(modelLedr), "final LEDR");
    checkEq(word_t'(hex), word_t'(modelHex), "final HEX");
  endtask

  // ==============================
  // Stimulus
  // ==============================
  initial begin
    RESET     = 1'b1;
    progWrite = 1'b0;
    progAddr  = '0;
    progData  = '0;
    void'($urandom(32'h28c9_e908));
    for (int t = 0; t < 4; t++) begin
      prog.delete();
      emit(encImm(ADDI, ioBase, 4'd0, 16'hF000));
      case (t)
        0: buildAluProgram();
        1: buildImmProgram();
        2: buildMemProgram();
        default: buildBranchProgram();
      endcase
      finishProgram(16'h0A00 + 16'(t));
      runTest(t, 16'h0A00 + 16'(t));
    end
    if (errorCount == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+bench
verilog/cpuPkg.sv
verilog/pipeIf.sv
verilog/instrFetch.sv
verilog/instrDecode.sv
verilog/executeStage.sv
verilog/resultStage.sv
verilog/cpuTop.sv
bench/pipeline_props.sv
bench/cpuTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJDIR)
